//--- filelist.f
vlsu_pkg.sv
vlsu_fifo.sv
vlsu_seq_load.sv
vlsu_shuffle.sv
vlsu_lane_queue.sv
vlsu_wb_arbiter.sv
vlsu_load_top.sv
vlsu_load_assertions.sv
tb_vlsu_load.sv

//--- Makefile
# Verilator flow for the sequential-load path testbench

VERILATOR  ?= verilator
TOP        := tb_vlsu_load
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST PASS

COMMON     := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall $(COMMON)
SIM_FLAGS  := --binary -j 0 -Wno-fatal --Mdir $(OBJ_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_vlsu_load.sv
// Directed testbench for the sequential-load path top level.
// Drives metadata, transaction control and AXI read beats, and checks every
// register-file write against a reference model of the packing rule.

`timescale 1ns/1ps

module tb_vlsu_load import vlsu_pkg::*; ();

  localparam int unsigned NrLanes = NrLanesDef;
  localparam int unsigned Timeout = 5000;

  logic                       clk, rst_n;
  logic                       axi_r_valid, axi_r_ready;
  axi_r_t                     axi_r;
  logic                       txn_valid, txn_ready;
  txn_ctrl_t                  txn;
  logic                       meta_valid, meta_ready;
  meta_t                      meta;
  logic                       wb_valid, wb_ready;
  lane_wr_t                   wb;
  logic [$clog2(NrLanes)-1:0] wb_lane;

  // Expected writes per lane, and the nibble stream of the current request
  lane_wr_t    exp_q [NrLanes][$];
  logic [3:0]  nib_q [$];
  integer      seed;
  integer      ready_seed;
  bit          random_ready;
  int unsigned n_checked;

  vlsu_load_top #(
    .NrLanes   (NrLanes),
    .MetaDepth (2),
    .LaneDepth (4)
  ) dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .axi_r_valid_i (axi_r_valid),
    .axi_r_ready_o (axi_r_ready),
    .axi_r_i       (axi_r),
    .txn_valid_i   (txn_valid),
    .txn_ready_o   (txn_ready),
    .txn_i         (txn),
    .meta_valid_i  (meta_valid),
    .meta_ready_o  (meta_ready),
    .meta_i        (meta),
    .wb_valid_o    (wb_valid),
    .wb_ready_i    (wb_ready),
    .wb_o          (wb),
    .wb_lane_o     (wb_lane)
  );

  always #10 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic int unsigned pending_writes();
    int unsigned total;
    total = 0;
    for (int unsigned j = 0; j < NrLanes; j++) begin
      total += exp_q[j].size();
    end
    return total;
  endfunction

  function automatic logic [LaneNibbles*4-1:0] nibble_mask(input logic [LaneNibbles-1:0] be);
    logic [LaneNibbles*4-1:0] m;
    for (int unsigned i = 0; i < LaneNibbles; i++) begin
      m[i*4 +: 4] = {4{be[i]}};
    end
    return m;
  endfunction

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // Packs the nibble stream into rows from the start pointer; a row closes
  // when full or at the end of the request, and empty slices are skipped
  task automatic model_request(input int unsigned start_ptr);
    logic [RowNibbles*4-1:0] nb;
    logic [RowNibbles-1:0]   en;
    int unsigned             pos;
    int unsigned             row;
    lane_wr_t                slice;
    pos = start_ptr;
    row = 0;
    nb  = '0;
    en  = '0;
    foreach (nib_q[i]) begin
      nb[pos*4 +: 4] = nib_q[i];
      en[pos]        = 1'b1;
      pos++;
      if ((pos == RowNibbles) || (i == nib_q.size() - 1)) begin
        for (int unsigned j = 0; j < NrLanes; j++) begin
          slice.data = nb[j*LaneNibbles*4 +: LaneNibbles*4];
          slice.be   = en[j*LaneNibbles +: LaneNibbles];
          slice.row  = RowIdxW'(row);
          if (|slice.be) begin
            exp_q[j].push_back(slice);
          end
        end
        nb  = '0;
        en  = '0;
        pos = 0;
        row++;
      end
    end
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  // Holds the stream until its ready is seen, then returns just after the edge
  task automatic wait_accept(input bit is_beat);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!(is_beat ? axi_r_ready : meta_ready)) begin
      cycles++;
      if (cycles > Timeout) begin
        stop_on_error(is_beat ? "Timeout waiting for a read beat to be accepted"
                              : "Timeout waiting for metadata to be accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  // One request of one transaction with random beat data
  task automatic run_request(input logic [7:0] vstart, input logic [1:0] sew,
                             input int unsigned head_nb, input int unsigned n_beats,
                             input int unsigned lb_nb);
    logic [BusNibbles*4-1:0] beat_q [$];
    int unsigned             lo;
    int unsigned             hi;
    nib_q.delete();
    // Full rows can leave before the last beat, so the whole request is
    // modelled before the first beat is driven
    for (int unsigned b = 0; b < n_beats; b++) begin
      beat_q.push_back(32'($random(seed)));
      lo = (b == 0) ? head_nb : 0;
      hi = (b == n_beats - 1) ? lb_nb : BusNibbles;
      for (int unsigned n = lo; n < hi; n++) begin
        nib_q.push_back(beat_q[b][n*4 +: 4]);
      end
    end
    model_request(((vstart % 16) << sew) % RowNibbles);
    meta_valid  = 1'b1;
    meta.vstart = vstart;
    meta.sew    = sew;
    wait_accept(1'b0);
    meta_valid  = 1'b0;
    for (int unsigned b = 0; b < n_beats; b++) begin
      axi_r.data   = beat_q[b];
      axi_r.last   = (b == n_beats - 1);
      txn.is_head  = (b == 0);
      txn.head_nb  = BusIdxW'(head_nb);
      txn.rmn_beat = 8'(n_beats - 1 - b);
      txn.lb_nb    = 4'(lb_nb);
      txn.is_final = 1'b1;
      axi_r_valid  = 1'b1;
      txn_valid    = 1'b1;
      wait_accept(1'b1);
    end
    axi_r_valid = 1'b0;
    txn_valid   = 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned cycles;
    cycles = 0;
    while (pending_writes() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > Timeout) begin
        stop_on_error("Timeout waiting for the expected writes to arrive");
      end
    end
    @(posedge clk);
    #2;
  endtask

  // Random back-pressure on the writeback port
  always @(posedge clk) begin
    #2;
    if (random_ready) begin
      wb_ready = 1'($random(ready_seed));
    end
  end

  // ==========================================================================
  // Writeback monitor
  // ==========================================================================

  always @(negedge clk) begin
    lane_wr_t                 exp;
    logic [LaneNibbles*4-1:0] mask;
    if (rst_n && wb_valid && wb_ready) begin
      assert (exp_q[wb_lane].size() != 0) else begin
        stop_on_error($sformatf("Unexpected write on lane %0d at %0t ns", wb_lane, $time));
      end
      exp  = exp_q[wb_lane].pop_front();
      mask = nibble_mask(exp.be);
      assert ((wb.be == exp.be) && ((wb.data & mask) == (exp.data & mask)) &&
              (wb.row == exp.row)) else begin
        stop_on_error($sformatf(
          "FAILED at %0t ns: lane %0d wrote data %h be %b row %0d, expected %h be %b row %0d",
          $time, wb_lane, wb.data, wb.be, wb.row, exp.data, exp.be, exp.row));
      end
      n_checked++;
    end
  end

  // ==========================================================================
  // Tests
  // ==========================================================================

  task automatic check_reset_state();
    @(negedge clk);
    assert (!axi_r_ready && !txn_ready && !wb_valid && meta_ready) else begin
      stop_on_error("Outputs were not in their idle state after reset");
    end
    @(posedge clk);
    #2;
  endtask

  task automatic test_aligned();
    run_request(8'd0, 2'd0, 0, 2, 8);
    wait_drain();
  endtask

  task automatic test_partial_row();
    run_request(8'd0, 2'd0, 3, 2, 5);
    wait_drain();
  endtask

  task automatic test_vstart_offset();
    run_request(8'd2, 2'd1, 0, 2, 4);
    wait_drain();
  endtask

  task automatic test_split_beats();
    run_request(8'd0, 2'd0, 2, 5, 8);
    wait_drain();
  endtask

  task automatic test_random();
    int unsigned head;
    int unsigned beats;
    int unsigned lb;
    random_ready = 1'b1;
    for (int r = 0; r < 30; r++) begin
      head  = $unsigned($random(seed)) % BusNibbles;
      beats = 1 + $unsigned($random(seed)) % 6;
      if (beats == 1) begin
        lb = head + 1 + $unsigned($random(seed)) % (BusNibbles - head);
      end else begin
        lb = 1 + $unsigned($random(seed)) % BusNibbles;
      end
      run_request(8'($random(seed)), 2'($random(seed)), head, beats, lb);
    end
    wait_drain();
    random_ready = 1'b0;
    wb_ready     = 1'b1;
  endtask

  initial begin
    seed         = 32'hba4c7b1e;
    ready_seed   = 32'hba4c7b1e;
    random_ready = 1'b0;
    n_checked    = 0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    axi_r_valid  = 1'b0;
    axi_r        = '0;
    txn_valid    = 1'b0;
    txn          = '0;
    meta_valid   = 1'b0;
    meta         = '0;
    wb_ready     = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_reset_state();
    test_aligned();
    test_partial_row();
    test_vstart_offset();
    test_split_beats();
    test_random();

    if (pending_writes() == 0) begin
      $display("%0d lane writes checked", n_checked);
      $display("TEST PASS");
      $finish;
    end else begin
      stop_on_error("Expected writes were still pending at the end of the run");
    end
  end

endmodule

//--- vlsu_load_assertions.sv
// Concurrent handshake checks on the load-path top level.
// Bound to every instance of vlsu_load_top by the bind at the end.

`timescale 1ns/1ps

module vlsu_load_assertions import vlsu_pkg::*; #(
  parameter int unsigned NrLanes = NrLanesDef
) (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       axi_r_valid_i,
  input logic                       axi_r_ready_o,
  input axi_r_t                     axi_r_i,
  input logic                       txn_valid_i,
  input logic                       txn_ready_o,
  input txn_ctrl_t                  txn_i,
  input logic                       meta_valid_i,
  input logic                       meta_ready_o,
  input meta_t                      meta_i,
  input logic                       wb_valid_o,
  input logic                       wb_ready_i,
  input lane_wr_t                   wb_o,
  input logic [$clog2(NrLanes)-1:0] wb_lane_o
);

  // Input streams hold valid and payload until the transfer
  axi_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_r_valid_i && !axi_r_ready_o |=> axi_r_valid_i && $stable(axi_r_i))
    else $error("AXI read beat dropped or changed before acceptance");

  txn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    txn_valid_i && !txn_ready_o |=> txn_valid_i && $stable(txn_i))
    else $error("Transaction control dropped or changed before acceptance");

  meta_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    meta_valid_i && !meta_ready_o |=> meta_valid_i && $stable(meta_i))
    else $error("Metadata dropped or changed before acceptance");

  // A new lane may win arbitration while stalled, the same lane keeps its data
  wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && (!$stable(wb_lane_o) || $stable(wb_o)))
    else $error("Writeback dropped or changed before acceptance");

  // Both readies rise together, and only for a beat offered on both streams
  ready_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (axi_r_ready_o == txn_ready_o) &&
    (!axi_r_ready_o || (axi_r_valid_i && txn_valid_i)))
    else $error("Read beat accepted without both streams valid, or the readies differ");

endmodule

bind vlsu_load_top vlsu_load_assertions #(
  .NrLanes (NrLanes)
) i_load_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .axi_r_valid_i (axi_r_valid_i),
  .axi_r_ready_o (axi_r_ready_o),
  .axi_r_i       (axi_r_i),
  .txn_valid_i   (txn_valid_i),
  .txn_ready_o   (txn_ready_o),
  .txn_i         (txn_i),
  .meta_valid_i  (meta_valid_i),
  .meta_ready_o  (meta_ready_o),
  .meta_i        (meta_i),
  .wb_valid_o    (wb_valid_o),
  .wb_ready_i    (wb_ready_i),
  .wb_o          (wb_o),
  .wb_lane_o     (wb_lane_o)
);

//--- vlsu_load_top.sv
// Sequential-load path top level: loader, shuffle, per-lane queues and
// writeback arbiter, with the lane count and queue depths set here.

`timescale 1ns/1ps

module vlsu_load_top import vlsu_pkg::*; #(
  parameter int unsigned NrLanes   = NrLanesDef,
  parameter int unsigned MetaDepth = 2,
  parameter int unsigned LaneDepth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       axi_r_valid_i,
  output logic                       axi_r_ready_o,
  input  axi_r_t                     axi_r_i,
  input  logic                       txn_valid_i,
  output logic                       txn_ready_o,
  input  txn_ctrl_t                  txn_i,
  input  logic                       meta_valid_i,
  output logic                       meta_ready_o,
  input  meta_t                      meta_i,
  output logic                       wb_valid_o,
  input  logic                       wb_ready_i,
  output lane_wr_t                   wb_o,
  output logic [$clog2(NrLanes)-1:0] wb_lane_o
);

  logic               row_valid, row_ready;
  seq_row_t           row;
  logic [NrLanes-1:0] lane_ready, push, q_valid, q_ready;
  lane_wr_t           slice  [NrLanes];
  lane_wr_t           q_data [NrLanes];

  vlsu_seq_load #(
    .MetaDepth (MetaDepth)
  ) i_seq_load (
    .clk_i, .rst_ni,
    .axi_r_valid_i, .axi_r_ready_o, .axi_r_i,
    .txn_valid_i, .txn_ready_o, .txn_i,
    .meta_valid_i, .meta_ready_o, .meta_i,
    .row_valid_o (row_valid),
    .row_ready_i (row_ready),
    .row_o       (row)
  );

  vlsu_shuffle #(
    .NrLanes (NrLanes)
  ) i_shuffle (
    .clk_i, .rst_ni,
    .row_valid_i  (row_valid),
    .row_ready_o  (row_ready),
    .row_i        (row),
    .lane_ready_i (lane_ready),
    .lane_push_o  (push),
    .lane_o       (slice)
  );

  for (genvar k = 0; k < NrLanes; k++) begin : gen_lane
    vlsu_lane_queue #(
      .Depth (LaneDepth)
    ) i_lane_queue (
      .clk_i, .rst_ni,
      .push_i    (push[k]),
      .wr_i      (slice[k]),
      .ready_o   (lane_ready[k]),
      .q_valid_o (q_valid[k]),
      .q_ready_i (q_ready[k]),
      .q_o       (q_data[k])
    );
  end

  vlsu_wb_arbiter #(
    .NrLanes (NrLanes)
  ) i_wb_arbiter (
    .clk_i, .rst_ni,
    .q_valid_i  (q_valid),
    .q_ready_o  (q_ready),
    .q_i        (q_data),
    .wb_valid_o, .wb_ready_i, .wb_o, .wb_lane_o
  );

endmodule

//--- vlsu_wb_arbiter.sv
// Round-robin writeback arbiter: drains the lane queues onto the single
// register-file write port, starting after the last granted lane.

`timescale 1ns/1ps

module vlsu_wb_arbiter import vlsu_pkg::*; #(
  parameter int unsigned NrLanes = NrLanesDef
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [NrLanes-1:0]         q_valid_i,
  output logic [NrLanes-1:0]         q_ready_o,
  input  lane_wr_t                   q_i [NrLanes],
  output logic                       wb_valid_o,
  input  logic                       wb_ready_i,
  output lane_wr_t                   wb_o,
  output logic [$clog2(NrLanes)-1:0] wb_lane_o
);

  localparam int unsigned LaneW = $clog2(NrLanes);

  logic [LaneW-1:0] last_q, gnt;
  logic             found;

  always_comb begin
    int unsigned idx;
    found = 1'b0;
    gnt   = last_q;
    for (int unsigned off = 1; off <= NrLanes; off++) begin
      idx = (32'(last_q) + off) % NrLanes;
      if (!found && q_valid_i[idx]) begin
        found = 1'b1;
        gnt   = LaneW'(idx);
      end
    end
  end

  assign wb_valid_o = found;
  assign wb_o       = q_i[gnt];
  assign wb_lane_o  = gnt;

  always_comb begin
    q_ready_o = '0;
    if (wb_valid_o && wb_ready_i) begin
      q_ready_o[gnt] = 1'b1;
    end
  end

  // Starts at the top lane so lane 0 wins first after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= LaneW'(NrLanes - 1);
    end else if (wb_valid_o && wb_ready_i) begin
      last_q <= gnt;
    end
  end

endmodule

//--- vlsu_lane_queue.sv
// Per-lane write queue: drops slices with no nibble enabled and buffers
// the rest in order until the writeback arbiter takes them.

`timescale 1ns/1ps

module vlsu_lane_queue import vlsu_pkg::*; #(
  parameter int unsigned Depth = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  lane_wr_t wr_i,
  output logic     ready_o,
  output logic     q_valid_o,
  input  logic     q_ready_i,
  output lane_wr_t q_o
);

  logic keep;

  // Empty slices never reach the register file
  assign keep = push_i && (|wr_i.be);

  vlsu_fifo #(
    .Depth (Depth),
    .T     (lane_wr_t)
  ) i_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (keep),
    .in_ready_o  (ready_o),
    .in_i        (wr_i),
    .out_valid_o (q_valid_o),
    .out_ready_i (q_ready_i),
    .out_o       (q_o)
  );

endmodule

//--- vlsu_shuffle.sv
// Shuffle stage: cuts each sequence-buffer row into lane slices and tags
// them with the row index within the request.

`timescale 1ns/1ps

module vlsu_shuffle import vlsu_pkg::*; #(
  parameter int unsigned NrLanes = NrLanesDef
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               row_valid_i,
  output logic               row_ready_o,
  input  seq_row_t           row_i,
  input  logic [NrLanes-1:0] lane_ready_i,
  output logic [NrLanes-1:0] lane_push_o,
  output lane_wr_t           lane_o [NrLanes]
);

  logic [RowIdxW-1:0] row_cnt_q;
  logic               row_xfer;

  // A row moves only when every lane can take its slice
  assign row_ready_o = &lane_ready_i;
  assign row_xfer    = row_valid_i && row_ready_o;

  for (genvar j = 0; j < NrLanes; j++) begin : gen_slice
    assign lane_push_o[j] = row_xfer;
    assign lane_o[j].data = row_i.nb[j*LaneNibbles*4 +: LaneNibbles*4];
    assign lane_o[j].be   = row_i.en[j*LaneNibbles +: LaneNibbles];
    assign lane_o[j].row  = row_cnt_q;
  end

  // Row index restarts after the closing row of each request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_cnt_q <= '0;
    end else if (row_xfer) begin
      if (row_i.last) begin
        row_cnt_q <= '0;
      end else begin
        row_cnt_q <= row_cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- vlsu_seq_load.sv
// Sequential loader: packs the valid nibbles of each AXI read beat into a
// two-entry ping-pong row buffer, starting at the vstart nibble offset.
// Full rows and the closing row of a request are handed to the shuffle.

`timescale 1ns/1ps

module vlsu_seq_load import vlsu_pkg::*; #(
  parameter int unsigned MetaDepth = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // AXI read data
  input  logic      axi_r_valid_i,
  output logic      axi_r_ready_o,
  input  axi_r_t    axi_r_i,
  // Per-beat transaction control
  input  logic      txn_valid_i,
  output logic      txn_ready_o,
  input  txn_ctrl_t txn_i,
  // Request metadata
  input  logic      meta_valid_i,
  output logic      meta_ready_o,
  input  meta_t     meta_i,
  // Rows towards the shuffle stage
  output logic      row_valid_o,
  input  logic      row_ready_i,
  output seq_row_t  row_o
);

  typedef enum logic {
    S_IDLE,
    S_COMMIT
  } state_e;

  state_e state_q, state_d;

  // ==========================================================================
  // Start pointer queue
  // ==========================================================================

  seq_info_t info_in, info_out;
  logic      info_valid, info_ready;

  assign info_in.start_ptr = meta_i.vstart[RowPtrW-1:0] << meta_i.sew;

  vlsu_fifo #(
    .Depth (MetaDepth),
    .T     (seq_info_t)
  ) i_info_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (meta_valid_i),
    .in_ready_o  (meta_ready_o),
    .in_i        (info_in),
    .out_valid_o (info_valid),
    .out_ready_i (info_ready),
    .out_o       (info_out)
  );

  // ==========================================================================
  // Ping-pong row buffer
  // ==========================================================================

  seq_row_t buf_q [2];
  seq_row_t buf_d [2];
  // Bit 1 is the wrap flag, bit 0 the entry index
  logic [1:0] wr_cnt_q, rd_cnt_q;
  logic       buf_full, buf_empty, row_enq, row_deq;

  assign buf_full  = (wr_cnt_q ^ rd_cnt_q) == 2'b10;
  assign buf_empty = wr_cnt_q == rd_cnt_q;

  assign row_valid_o = !buf_empty;
  assign row_o       = buf_q[rd_cnt_q[0]];
  assign row_deq     = row_valid_o && row_ready_i;

  // ==========================================================================
  // Beat commit
  // ==========================================================================

  logic [BusIdxW-1:0] bus_cnt_q, bus_cnt_d;
  logic [RowPtrW-1:0] ptr_q, ptr_d;
  logic [3:0]         lower_nb, upper_nb, bus_avail, start_nb;
  logic [RowPtrW:0]   row_free, n_cmt;
  logic               do_cmt, accept, final_beat;

  // R last closes each burst, the final one closes the request
  assign final_beat = txn_i.is_final && axi_r_i.last;
  assign lower_nb   = txn_i.is_head ? {1'b0, txn_i.head_nb} : 4'd0;
  assign upper_nb   = (txn_i.rmn_beat == '0) ? txn_i.lb_nb : 4'(BusNibbles);
  // Nibbles of this beat not yet written to a row
  assign bus_avail  = upper_nb - lower_nb - {1'b0, bus_cnt_q};
  assign row_free   = (RowPtrW+1)'(RowNibbles) - {1'b0, ptr_q};
  assign start_nb   = lower_nb + {1'b0, bus_cnt_q};
  assign do_cmt     = (state_q == S_COMMIT) && axi_r_valid_i && txn_valid_i && !buf_full;

  assign axi_r_ready_o = accept;
  assign txn_ready_o   = accept;

  always_comb begin
    state_d    = state_q;
    bus_cnt_d  = bus_cnt_q;
    ptr_d      = ptr_q;
    buf_d      = buf_q;
    info_ready = 1'b0;
    accept     = 1'b0;
    row_enq    = 1'b0;
    n_cmt      = '0;

    if (state_q == S_IDLE) begin
      if (txn_valid_i && info_valid) begin
        info_ready = 1'b1;
        bus_cnt_d  = '0;
        ptr_d      = info_out.start_ptr;
        state_d    = S_COMMIT;
      end
    end else if (do_cmt) begin
      if ({1'b0, bus_avail} > row_free) begin
        // Row fills first, the rest of the beat goes to the next row
        n_cmt     = row_free;
        bus_cnt_d = bus_cnt_q + BusIdxW'(row_free);
        ptr_d     = '0;
        row_enq   = 1'b1;
      end else begin
        n_cmt     = {1'b0, bus_avail};
        bus_cnt_d = '0;
        ptr_d     = ptr_q + bus_avail;
        accept    = 1'b1;
        if (({1'b0, bus_avail} == row_free) || final_beat) begin
          ptr_d   = '0;
          row_enq = 1'b1;
        end
        if (final_beat) begin
          state_d = S_IDLE;
        end
      end

      for (int unsigned i = 0; i < RowNibbles; i++) begin
        if ((i >= ptr_q) && (i < ptr_q + n_cmt)) begin
          buf_d[wr_cnt_q[0]].nb[i*4 +: 4] =
            axi_r_i.data[BusIdxW'(i + start_nb - ptr_q)*4 +: 4];
          buf_d[wr_cnt_q[0]].en[i] = 1'b1;
        end
      end
      buf_d[wr_cnt_q[0]].last = row_enq && accept && final_beat;
    end

    // Taken rows are cleared so the entry can accumulate again
    if (row_deq) begin
      buf_d[rd_cnt_q[0]] = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      bus_cnt_q <= '0;
      ptr_q     <= '0;
      wr_cnt_q  <= '0;
      rd_cnt_q  <= '0;
      buf_q[0]  <= '0;
      buf_q[1]  <= '0;
    end else begin
      state_q   <= state_d;
      bus_cnt_q <= bus_cnt_d;
      ptr_q     <= ptr_d;
      buf_q     <= buf_d;
      if (row_enq) begin
        wr_cnt_q <= wr_cnt_q + 2'd1;
      end
      if (row_deq) begin
        rd_cnt_q <= rd_cnt_q + 2'd1;
      end
    end
  end

endmodule

//--- vlsu_fifo.sv
// Valid/ready FIFO with registered output and a type-parameter payload.
// Serves both the metadata info queue and the per-lane slice queues.

`timescale 1ns/1ps

module vlsu_fifo #(
  parameter int unsigned Depth = 4,
  parameter type         T     = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_o
);

  localparam int unsigned IdxW = (Depth > 1) ? $clog2(Depth) : 1;

  T                mem_q [Depth];
  logic [IdxW-1:0] wr_idx_q, rd_idx_q;
  logic            wr_flag_q, rd_flag_q;
  logic            full, empty, push, pop;

  // Same index with different wrap flags means the writer lapped the reader
  assign full  = (wr_idx_q == rd_idx_q) && (wr_flag_q != rd_flag_q);
  assign empty = (wr_idx_q == rd_idx_q) && (wr_flag_q == rd_flag_q);

  assign in_ready_o  = !full;
  assign out_valid_o = !empty;
  assign out_o       = mem_q[rd_idx_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q  <= '0;
      rd_idx_q  <= '0;
      wr_flag_q <= 1'b0;
      rd_flag_q <= 1'b0;
    end else begin
      if (push) begin
        if (wr_idx_q == IdxW'(Depth - 1)) begin
          wr_idx_q  <= '0;
          wr_flag_q <= ~wr_flag_q;
        end else begin
          wr_idx_q <= wr_idx_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_idx_q == IdxW'(Depth - 1)) begin
          rd_idx_q  <= '0;
          rd_flag_q <= ~rd_flag_q;
        end else begin
          rd_idx_q <= rd_idx_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_idx_q] <= in_i;
    end
  end

endmodule

//--- vlsu_pkg.sv
// Shared widths and packed payload types of the sequential-load path.
// Every RTL block imports this package with a wildcard import.

package vlsu_pkg;

  // ==========================================================================
  // Width constants
  // ==========================================================================

  // 32-bit AXI data bus
  localparam int unsigned BusNibbles  = 8;
  localparam int unsigned BusIdxW     = $clog2(BusNibbles);
  // 16-bit lanes
  localparam int unsigned LaneNibbles = 4;
  localparam int unsigned NrLanesDef  = 4;
  // One sequence-buffer row spans all lanes
  localparam int unsigned RowNibbles  = LaneNibbles * NrLanesDef;
  localparam int unsigned RowPtrW     = $clog2(RowNibbles);
  localparam int unsigned RowIdxW     = 4;

  // ==========================================================================
  // Stream payloads
  // ==========================================================================

  typedef struct packed {
    logic [BusNibbles*4-1:0] data;
    logic                    last;
  } axi_r_t;

  // Per-beat description of the read transaction
  typedef struct packed {
    logic               is_head;
    logic [BusIdxW-1:0] head_nb;
    logic [7:0]         rmn_beat;
    logic [3:0]         lb_nb;     // 1 to BusNibbles
    logic               is_final;
  } txn_ctrl_t;

  // Element size in nibbles is 2**sew
  typedef struct packed {
    logic [7:0] vstart;
    logic [1:0] sew;
  } meta_t;

  typedef struct packed {
    logic [RowNibbles*4-1:0] nb;
    logic [RowNibbles-1:0]   en;
    logic                    last;
  } seq_row_t;

  typedef struct packed {
    logic [LaneNibbles*4-1:0] data;
    logic [LaneNibbles-1:0]   be;
    logic [RowIdxW-1:0]       row;
  } lane_wr_t;

  typedef struct packed {
    logic [RowPtrW-1:0] start_ptr;
  } seq_info_t;

endpackage
